// File: verilog/card_game_consts.svh
`ifndef CARD_GAME_CONSTS_SVH
`define CARD_GAME_CONSTS_SVH

// keypad codes, one per player.
`define KEY_P1_FLIP 4'b0011
`define KEY_P2_FLIP 4'b0001

// shift register start value, must be non-zero.
`define LFSR_SEED 5'b11100

// flips in one round.
`define ROUND_FLIPS 8'd20

// same-colour numbers adding up to this ring the bell.
`define BELL_SUM 4'd5

`endif

// File: verilog/card_game_pkg.sv
package card_game_pkg;

    // one draw word, seen either as the register bits
    // or as the two selectors the table decodes.
    typedef union packed {
        logic [4:0] raw;
        struct packed {
            logic [1:0] color_sel; // upper bits.
            logic [2:0] number_sel;
        } fields;
    } card_word_t;

endpackage

// File: verilog/card_bus.sv
`timescale 1ns/1ns

interface card_bus;

    logic [1:0] card1_color;
    logic [2:0] card1_number;
    logic [1:0] card2_color;
    logic [2:0] card2_number;

    // the table owns the face-up cards.
    modport table_side (
        output card1_color,
        output card1_number,
        output card2_color,
        output card2_number
    );

    modport judge (
        input card1_color,
        input card1_number,
        input card2_color,
        input card2_number
    );

endinterface

// File: verilog/turn_fsm.sv
`timescale 1ns/1ns
`include "card_game_consts.svh"

module turn_fsm (
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] keypad,
    input  logic       round_over,
    output logic       flip,
    output logic       whose
);

    localparam logic turn1 = 1'b0;
    localparam logic turn2 = 1'b1;

    logic state;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= turn1;
            flip  <= 1'b0;
            whose <= 1'b0;
        end else begin
            flip <= 1'b0; // pulse lasts one cycle.
            if (!round_over) begin
                case (state)
                    turn1: begin
                        if (keypad == `KEY_P1_FLIP) begin
                            state <= turn2;
                            flip  <= 1'b1;
                            whose <= 1'b1; // card goes to player 1.
                        end
                    end
                    turn2: begin
                        if (keypad == `KEY_P2_FLIP) begin
                            state <= turn1;
                            flip  <= 1'b1;
                            whose <= 1'b0;
                        end
                    end
                    default: state <= turn1;
                endcase
            end
        end
    end

    a_flip_single: assert property (@(posedge clk) disable iff (!rst) flip |=> !flip)
        else $error("turn_fsm: flip held for two cycles.");

endmodule

// File: verilog/flip_counter.sv
`timescale 1ns/1ns
`include "card_game_consts.svh"

module flip_counter (
    input  logic       clk,
    input  logic       rst,
    input  logic       flip,
    input  logic       new_round,
    output logic [7:0] flip_count,
    output logic       round_over
);

    assign round_over = (flip_count == `ROUND_FLIPS);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            flip_count <= 8'd0;
        end else if (new_round) begin
            flip_count <= 8'd0; // new round beats a late flip.
        end else if (flip && !round_over) begin
            flip_count <= flip_count + 8'd1;
        end
    end

    // a flip can still arrive on the edge the count saturates.
    a_count_bound: assert property (
        @(posedge clk) disable iff (!rst) flip_count <= `ROUND_FLIPS
    ) else $error("flip_counter: count past round length.");

endmodule

// File: verilog/card_lfsr.sv
`timescale 1ns/1ns
`include "card_game_consts.svh"

module card_lfsr (
    input  logic                     clk,
    input  logic                     rst,
    output card_game_pkg::card_word_t draw
);

    logic [4:0] next_raw;

    // shift left, feedback from taps 4 and 2.
    assign next_raw = {draw.raw[3:0], draw.raw[4] ^ draw.raw[2]};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            draw.raw <= `LFSR_SEED;
        end else begin
            draw.raw <= next_raw; // steps every cycle.
        end
    end

    // all-zero would lock the sequence up.
    a_never_zero: assert property (@(posedge clk) disable iff (!rst) draw.raw != 5'd0)
        else $error("card_lfsr: register reached zero.");

endmodule

// File: verilog/card_table.sv
`timescale 1ns/1ns

module card_table (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flip,
    input  logic                      whose,
    input  logic                      new_round,
    input  card_game_pkg::card_word_t draw,
    card_bus.table_side               cards
);

    logic [1:0] draw_color;
    logic [2:0] draw_number;

    // colour 1..3, number 1..5.
    assign draw_color  = (draw.fields.color_sel % 2'd3) + 2'd1;
    assign draw_number = (draw.fields.number_sel % 3'd5) + 3'd1;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cards.card1_color  <= 2'd0;
            cards.card1_number <= 3'd0;
            cards.card2_color  <= 2'd0;
            cards.card2_number <= 3'd0;
        end else if (new_round) begin
            cards.card1_color  <= 2'd0; // table cleared.
            cards.card1_number <= 3'd0;
            cards.card2_color  <= 2'd0;
            cards.card2_number <= 3'd0;
        end else if (flip) begin
            if (whose) begin
                cards.card1_color  <= draw_color;
                cards.card1_number <= draw_number;
            end else begin
                cards.card2_color  <= draw_color;
                cards.card2_number <= draw_number;
            end
        end
    end

    // an empty slot holds no number.
    a_card_whole: assert property (
        @(posedge clk) disable iff (!rst)
        (cards.card1_color != 2'd0 || cards.card1_number == 3'd0) &&
        (cards.card2_color != 2'd0 || cards.card2_number == 3'd0)
    ) else $error("card_table: number stored without a colour.");

endmodule

// File: verilog/bell_judge.sv
`timescale 1ns/1ns
`include "card_game_consts.svh"

module bell_judge (
    input  logic  clk,
    input  logic  rst,
    card_bus.judge cards,
    output logic  bell
);

    logic [3:0] sum;
    logic       match;

    assign sum = {1'b0, cards.card1_number} + {1'b0, cards.card2_number};

    // equal colours and card1 present means card2 is present too.
    assign match = (cards.card1_color != 2'd0)
                && (cards.card1_color == cards.card2_color)
                && (sum == `BELL_SUM);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            bell <= 1'b0;
        end else begin
            bell <= match; // level, follows the table.
        end
    end

    // bell lags the table by one edge, so look at the cards it was judged on.
    a_bell_cards: assert property (
        @(posedge clk) disable iff (!rst)
        $rose(bell) |-> ($past(cards.card1_color) != 2'd0) &&
                        ($past(cards.card2_color) != 2'd0)
    ) else $error("bell_judge: bell rang on an empty slot.");

endmodule

// File: verilog/card_game_top.sv
`timescale 1ns/1ns

module card_game_top (
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] keypad,
    input  logic       new_round,
    output logic       whose,
    output logic [7:0] flip_count,
    output logic [1:0] card1_color,
    output logic [2:0] card1_number,
    output logic [1:0] card2_color,
    output logic [2:0] card2_number,
    output logic       bell,
    output logic       round_over
);

    import card_game_pkg::*;

    card_word_t draw;
    logic       flip;

    card_bus cards ();

    turn_fsm u_turn_fsm (
        .clk        (clk),
        .rst        (rst),
        .keypad     (keypad),
        .round_over (round_over),
        .flip       (flip),
        .whose      (whose)
    );

    flip_counter u_flip_counter (
        .clk        (clk),
        .rst        (rst),
        .flip       (flip),
        .new_round  (new_round),
        .flip_count (flip_count),
        .round_over (round_over)
    );

    card_lfsr u_card_lfsr (
        .clk  (clk),
        .rst  (rst),
        .draw (draw)
    );

    card_table u_card_table (
        .clk       (clk),
        .rst       (rst),
        .flip      (flip),
        .whose     (whose),
        .new_round (new_round),
        .draw      (draw),
        .cards     (cards)
    );

    bell_judge u_bell_judge (
        .clk   (clk),
        .rst   (rst),
        .cards (cards),
        .bell  (bell)
    );

    // face-up cards out to the board.
    assign card1_color  = cards.card1_color;
    assign card1_number = cards.card1_number;
    assign card2_color  = cards.card2_color;
    assign card2_number = cards.card2_number;

endmodule

// File: bench/card_game_tb.sv
`timescale 1ns/1ns
`include "card_game_consts.svh"

module card_game_tb;

    import card_game_pkg::*;

    localparam int clk_period = 10;
    // reset, turn order, idle keys, two bell pairs, round end, margin.
    localparam int budget_cycles = 5 + 30 + 25 + 2 * 75 + `ROUND_FLIPS * 8 + 30 + 100;

    logic       clk;
    logic       rst;
    logic [3:0] keypad;
    logic       new_round;
    logic       whose;
    logic [7:0] flip_count;
    logic [1:0] card1_color;
    logic [2:0] card1_number;
    logic [1:0] card2_color;
    logic [2:0] card2_number;
    logic       bell;
    logic       round_over;

    card_word_t  model_draw; // reference copy of the draw register.
    logic [31:0] rng;
    logic [1:0]  exp_c1_col;
    logic [2:0]  exp_c1_num;
    logic [1:0]  exp_c2_col;
    logic [2:0]  exp_c2_num;
    logic [7:0]  exp_count;
    logic        p1_turn;
    int          errors;
    int          tests_run;
    int          tests_failed;

    card_game_top DUT (
        .clk          (clk),
        .rst          (rst),
        .keypad       (keypad),
        .new_round    (new_round),
        .whose        (whose),
        .flip_count   (flip_count),
        .card1_color  (card1_color),
        .card1_number (card1_number),
        .card2_color  (card2_color),
        .card2_number (card2_number),
        .bell         (bell),
        .round_over   (round_over)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // 5-bit shift left, new bit 0 from bits 4 and 2.
    function automatic logic [4:0] draw_step(input logic [4:0] r);
        return {r[3:0], r[4] ^ r[2]};
    endfunction

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            model_draw.raw <= `LFSR_SEED;
        end else begin
            model_draw.raw <= draw_step(model_draw.raw);
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32, 22, 2, 1.
    endfunction

    function automatic logic [1:0] decode_color(input logic [1:0] sel);
        int v;
        v = int'(sel) % 3 + 1;
        return v[1:0];
    endfunction

    function automatic logic [2:0] decode_number(input logic [2:0] sel);
        int v;
        v = int'(sel) % 5 + 1;
        return v[2:0];
    endfunction

    function automatic logic bell_rule(input logic [1:0] col1, input logic [2:0] num1,
                                       input logic [1:0] col2, input logic [2:0] num2);
        return (col1 != 2'd0) && (col2 != 2'd0) && (col1 == col2)
            && ((int'(num1) + int'(num2)) == int'(`BELL_SUM));
    endfunction

    task automatic random_key(input logic [3:0] avoid, output logic [3:0] key);
        for (int i = 0; i < 4; i++) begin
            rng = lfsr_next(rng);
            key[i] = rng[0];
        end
        if (key == avoid) begin
            key[3] = 1'b1; // neither flip code has bit 3 set.
        end
    endtask

    task automatic check_card(input string name, input logic [1:0] exp_col,
                              input logic [2:0] exp_num, input logic [1:0] act_col,
                              input logic [2:0] act_num);
        if (exp_col !== act_col || exp_num !== act_num) begin
            $display("MISMATCH at %0t: %s expected %0d/%0d, got %0d/%0d",
                     $time, name, exp_col, exp_num, act_col, act_num);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp_val, input logic act_val);
        if (exp_val !== act_val) begin
            $display("MISMATCH at %0t: %s expected %0b, got %0b", $time, name, exp_val, act_val);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input logic [7:0] exp_val,
                               input logic [7:0] act_val);
        if (exp_val !== act_val) begin
            $display("MISMATCH at %0t: %s expected %0d, got %0d", $time, name, exp_val, act_val);
            errors++;
        end
    endtask

    task automatic check_table();
        check_card("card1", exp_c1_col, exp_c1_num, card1_color, card1_number);
        check_card("card2", exp_c2_col, exp_c2_num, card2_color, card2_number);
        check_count("flip_count", exp_count, flip_count);
        check_bit("round_over", exp_count == `ROUND_FLIPS, round_over);
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests_run++;
        if (errors == start_errors) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - start_errors);
        end
    endtask

    // flip for the player whose turn it is, after some idle cycles.
    task automatic flip_card(input int idle);
        logic [3:0] key;
        logic [3:0] code;
        logic [3:0] next_code;
        code = p1_turn ? `KEY_P1_FLIP : `KEY_P2_FLIP;
        next_code = p1_turn ? `KEY_P2_FLIP : `KEY_P1_FLIP;
        repeat (idle) begin
            @(posedge clk);
            random_key(code, key);
            keypad <= key;
        end
        @(posedge clk);
        keypad <= code;
        @(posedge clk); // key sampled here.
        random_key(next_code, key);
        keypad <= key;
        @(negedge clk);
        check_bit("whose", p1_turn, whose);
        // this draw is latched on the next edge.
        if (p1_turn) begin
            exp_c1_col = decode_color(model_draw.fields.color_sel);
            exp_c1_num = decode_number(model_draw.fields.number_sel);
        end else begin
            exp_c2_col = decode_color(model_draw.fields.color_sel);
            exp_c2_num = decode_number(model_draw.fields.number_sel);
        end
        exp_count = exp_count + 8'd1;
        p1_turn = !p1_turn;
        @(posedge clk);
        @(negedge clk);
        check_table();
    endtask

    task automatic press_ignored(input logic [3:0] code);
        logic [3:0] key;
        @(posedge clk);
        keypad <= code;
        @(posedge clk);
        random_key(p1_turn ? `KEY_P1_FLIP : `KEY_P2_FLIP, key);
        keypad <= key;
        @(posedge clk);
        @(negedge clk);
        check_bit("whose", !p1_turn, whose); // still the last flipper.
        check_table();
    endtask

    task automatic check_bell_after_pair();
        @(posedge clk);
        @(negedge clk);
        check_bit("bell", bell_rule(exp_c1_col, exp_c1_num, exp_c2_col, exp_c2_num), bell);
    endtask

    // search ahead in the draw sequence for two flip gaps with the wanted bell.
    task automatic find_gaps(input logic want, output int gap1, output int gap2,
                             output logic found);
        card_word_t w1;
        card_word_t w2;
        found = 1'b0;
        gap1 = 0;
        gap2 = 0;
        w1.raw = draw_step(draw_step(model_draw.raw));
        for (int d1 = 0; d1 < 31; d1++) begin
            w2.raw = draw_step(draw_step(draw_step(w1.raw)));
            for (int d2 = 0; d2 < 31; d2++) begin
                if (!found && bell_rule(decode_color(w1.fields.color_sel),
                                        decode_number(w1.fields.number_sel),
                                        decode_color(w2.fields.color_sel),
                                        decode_number(w2.fields.number_sel)) == want) begin
                    found = 1'b1;
                    gap1 = d1;
                    gap2 = d2;
                end
                w2.raw = draw_step(w2.raw);
            end
            w1.raw = draw_step(w1.raw);
        end
    endtask

    task automatic bell_case(input logic want);
        int   gap1;
        int   gap2;
        logic found;
        find_gaps(want, gap1, gap2, found);
        if (!found) begin
            $display("no flip timing in the draw sequence gives bell %0b", want);
            errors++;
        end else begin
            flip_card(gap1);
            flip_card(gap2);
            check_bell_after_pair();
        end
    endtask

    task automatic test_reset();
        int start_errors;
        start_errors = errors;
        check_bit("bell", 1'b0, bell);
        check_bit("whose", 1'b0, whose);
        check_table();
        report_test("reset", start_errors);
    endtask

    task automatic test_turn_order();
        int start_errors;
        start_errors = errors;
        press_ignored(`KEY_P2_FLIP);
        flip_card(1);
        flip_card(1);
        check_bell_after_pair();
        report_test("turn order", start_errors);
    endtask

    task automatic test_idle_keys();
        int         start_errors;
        logic [3:0] key;
        start_errors = errors;
        repeat (16) begin
            @(posedge clk);
            random_key(p1_turn ? `KEY_P1_FLIP : `KEY_P2_FLIP, key);
            keypad <= key;
        end
        @(posedge clk);
        @(negedge clk);
        check_bit("whose", !p1_turn, whose);
        check_table();
        report_test("idle keys", start_errors);
    endtask

    task automatic test_bell();
        int start_errors;
        start_errors = errors;
        bell_case(1'b1);
        bell_case(1'b0);
        report_test("bell", start_errors);
    endtask

    task automatic test_round_end();
        int start_errors;
        start_errors = errors;
        while (exp_count < `ROUND_FLIPS) begin
            flip_card(1);
        end
        check_bit("round_over", 1'b1, round_over);
        press_ignored(p1_turn ? `KEY_P1_FLIP : `KEY_P2_FLIP);
        @(posedge clk);
        new_round <= 1'b1;
        @(posedge clk);
        new_round <= 1'b0;
        @(negedge clk);
        exp_c1_col = 2'd0;
        exp_c1_num = 3'd0;
        exp_c2_col = 2'd0;
        exp_c2_num = 3'd0;
        exp_count = 8'd0;
        check_table();
        flip_card(1); // turn order survives the new round.
        report_test("round end", start_errors);
    endtask

    initial begin
        rst = 1'b0;
        keypad = 4'h0;
        new_round = 1'b0;
        rng = 32'h415f_c3e0;
        exp_c1_col = 2'd0;
        exp_c1_num = 3'd0;
        exp_c2_col = 2'd0;
        exp_c2_num = 3'd0;
        exp_count = 8'd0;
        p1_turn = 1'b1;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        test_reset();
        test_turn_order();
        test_idle_keys();
        test_bell();
        test_round_end();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(budget_cycles * clk_period);
        $display("timeout: tests did not finish within %0d cycles", budget_cycles);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+verilog
verilog/card_game_pkg.sv
verilog/card_bus.sv
verilog/turn_fsm.sv
verilog/flip_counter.sv
verilog/card_lfsr.sv
verilog/card_table.sv
verilog/bell_judge.sv
verilog/card_game_top.sv
bench/card_game_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the card game testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f verilog.f --top-module card_game_tb -o card_game_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

output=$(./obj_dir/card_game_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^TB PASSED$"; then
    exit 0
fi
exit 1
